//--- common/vbe_consts.svh
`ifndef VBE_CONSTS_SVH
`define VBE_CONSTS_SVH

// Front-end offer width and issue width
`define VBE_ISSUE_LANE 4
`define VBE_NUM_ALU    2

// Two source operands per ALU lane
`define VBE_NUM_RD     (2 * `VBE_NUM_ALU)

// Command queue
`define VBE_CQ_DEPTH   8
`define VBE_CQ_CNT_W   ($clog2(`VBE_CQ_DEPTH + 1))

// Vector register geometry, SEW 8 and LMUL 1 only
`define VBE_VLEN       128
`define VBE_SEW        8
`define VBE_NUM_ELEM   (`VBE_VLEN / `VBE_SEW)
`define VBE_NUM_VREG   32

`endif

//--- common/vbe_pkg.sv
`include "vbe_consts.svh"

package vbe_pkg;

    // Element-wise ALU operations
    typedef enum logic [1:0] {
        OP_ADD   = 2'd0,
        OP_SUB   = 2'd1,
        OP_SADDU = 2'd2,
        OP_SSUBU = 2'd3
    } vec_op_e;

    typedef logic [$clog2(`VBE_NUM_VREG)-1:0] vreg_idx_t;

    typedef logic [`VBE_VLEN-1:0] vreg_data_t;

    // One instruction as offered by the front end
    // Subtract forms compute vs2 - vs1
    typedef struct packed {
        vec_op_e   op;
        vreg_idx_t vd;
        vreg_idx_t vs1;
        vreg_idx_t vs2;
    } vec_cmd_t;

    // Lane output register contents
    typedef struct packed {
        vreg_idx_t  vd;
        vreg_data_t data;
        logic       sat;
    } lane_result_t;

endpackage

//--- cmd_queue/cmd_queue.sv
`timescale 1ns/1ns
`include "vbe_consts.svh"

module cmd_queue #(
    parameter int DEPTH = `VBE_CQ_DEPTH
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`VBE_ISSUE_LANE-1:0]              push_valid,
    input  vbe_pkg::vec_cmd_t [`VBE_ISSUE_LANE-1:0] push_cmd,
    output logic [`VBE_ISSUE_LANE-1:0]              ready,
    output vbe_pkg::vec_cmd_t                       head0,
    output vbe_pkg::vec_cmd_t                       head1,
    output logic [$clog2(DEPTH+1)-1:0]              count,
    input  logic [1:0]                              pop_count
);
    import vbe_pkg::*;

    // DEPTH is a power of two, so pointers wrap without compare
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int PUSH_W = $clog2(`VBE_ISSUE_LANE + 1);

    vec_cmd_t                   mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           free_slots;
    logic [`VBE_ISSUE_LANE-1:0] push_acc;
    logic [PUSH_W-1:0]          push_num;
    logic [PTR_W-1:0]           wr_addr [`VBE_ISSUE_LANE];

    // Ready thermometer from fill level only
    assign free_slots = CNT_W'(DEPTH) - count;

    always_comb begin
        for (int k = 0; k < `VBE_ISSUE_LANE; k++) begin
            ready[k] = free_slots > CNT_W'(k);
        end
    end

    assign push_acc = push_valid & ready;

    // Each accepted lane lands after the older accepted lanes
    always_comb begin
        push_num = '0;
        for (int k = 0; k < `VBE_ISSUE_LANE; k++) begin
            wr_addr[k] = wr_ptr + PTR_W'(push_num);
            push_num   = push_num + PUSH_W'(push_acc[k]);
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `VBE_ISSUE_LANE; k++) begin
            if (push_acc[k]) begin
                mem[wr_addr[k]] <= push_cmd[k];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push_num);
            rd_ptr <= rd_ptr + PTR_W'(pop_count);
            count  <= count + CNT_W'(push_num) - CNT_W'(pop_count);
        end
    end

    // Two oldest entries, meaningful only as far as count says
    assign head0 = mem[rd_ptr];
    assign head1 = mem[rd_ptr + PTR_W'(1)];

endmodule

//--- design/issue_ctrl.sv
`timescale 1ns/1ns
`include "vbe_consts.svh"

module issue_ctrl (
    input  vbe_pkg::vec_cmd_t                      head0,
    input  vbe_pkg::vec_cmd_t                      head1,
    input  logic [`VBE_CQ_CNT_W-1:0]               count,
    input  logic [`VBE_NUM_ALU-1:0]                lane_busy,
    input  vbe_pkg::vreg_idx_t [`VBE_NUM_ALU-1:0]  lane_vd,
    output logic [1:0]                             pop_count,
    output logic [`VBE_NUM_ALU-1:0]                issue_valid,
    output vbe_pkg::vec_op_e [`VBE_NUM_ALU-1:0]    issue_op,
    output vbe_pkg::vreg_idx_t [`VBE_NUM_ALU-1:0]  issue_vd,
    output vbe_pkg::vreg_idx_t [`VBE_NUM_RD-1:0]   rd_idx
);
    import vbe_pkg::*;

    localparam int CNT_W = `VBE_CQ_CNT_W;

    logic head0_go;
    logic head1_go;

    // True when a valid lane register still holds a result for src
    function automatic logic in_flight(input vreg_idx_t                   src,
                                       input logic [`VBE_NUM_ALU-1:0]     busy,
                                       input vreg_idx_t [`VBE_NUM_ALU-1:0] vd);
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < `VBE_NUM_ALU; l++) begin
            hit = hit | (busy[l] && (vd[l] == src));
        end
        return hit;
    endfunction

    assign head0_go = (count != '0)
                   && !in_flight(head0.vs1, lane_busy, lane_vd)
                   && !in_flight(head0.vs2, lane_busy, lane_vd);

    // Younger head also waits on the older one issuing beside it
    assign head1_go = head0_go
                   && (count >= CNT_W'(2))
                   && (head1.vs1 != head0.vd)
                   && (head1.vs2 != head0.vd)
                   && !in_flight(head1.vs1, lane_busy, lane_vd)
                   && !in_flight(head1.vs2, lane_busy, lane_vd);

    assign pop_count   = 2'(head0_go) + 2'(head1_go);
    assign issue_valid = {head1_go, head0_go};

    // Lane 0 always takes the older command
    assign issue_op[0] = head0.op;
    assign issue_op[1] = head1.op;
    assign issue_vd[0] = head0.vd;
    assign issue_vd[1] = head1.vd;

    // Read ports per lane: vs2 feeds opa, vs1 feeds opb
    assign rd_idx[0] = head0.vs2;
    assign rd_idx[1] = head0.vs1;
    assign rd_idx[2] = head1.vs2;
    assign rd_idx[3] = head1.vs1;

endmodule

//--- design/vec_alu_lane.sv
`timescale 1ns/1ns
`include "vbe_consts.svh"

module vec_alu_lane (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    input  vbe_pkg::vec_op_e      op,
    input  vbe_pkg::vreg_idx_t    vd,
    input  vbe_pkg::vreg_data_t   opa,
    input  vbe_pkg::vreg_data_t   opb,
    output logic                  result_valid,
    output vbe_pkg::lane_result_t result
);
    import vbe_pkg::*;

    vreg_data_t               elem_res;
    logic [`VBE_NUM_ELEM-1:0] elem_sat;

    always_comb begin
        logic [`VBE_SEW:0] sum;
        logic [`VBE_SEW:0] diff;
        for (int e = 0; e < `VBE_NUM_ELEM; e++) begin
            sum  = {1'b0, opa[e*`VBE_SEW +: `VBE_SEW]} + {1'b0, opb[e*`VBE_SEW +: `VBE_SEW]};
            diff = {1'b0, opa[e*`VBE_SEW +: `VBE_SEW]} - {1'b0, opb[e*`VBE_SEW +: `VBE_SEW]};
            elem_res[e*`VBE_SEW +: `VBE_SEW] = sum[`VBE_SEW-1:0];
            elem_sat[e] = 1'b0;
            case (op)
                OP_SUB: begin
                    elem_res[e*`VBE_SEW +: `VBE_SEW] = diff[`VBE_SEW-1:0];
                end
                // Carry out means clamp to all ones
                OP_SADDU: begin
                    elem_res[e*`VBE_SEW +: `VBE_SEW] = sum[`VBE_SEW] ? '1 : sum[`VBE_SEW-1:0];
                    elem_sat[e] = sum[`VBE_SEW];
                end
                // Borrow means clamp to zero
                OP_SSUBU: begin
                    elem_res[e*`VBE_SEW +: `VBE_SEW] = diff[`VBE_SEW] ? '0 : diff[`VBE_SEW-1:0];
                    elem_sat[e] = diff[`VBE_SEW];
                end
                default: begin
                    elem_res[e*`VBE_SEW +: `VBE_SEW] = sum[`VBE_SEW-1:0];
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            result.vd   <= vd;
            result.data <= elem_res;
            result.sat  <= |elem_sat;
        end
    end

endmodule

//--- design/vrf.sv
`timescale 1ns/1ns
`include "vbe_consts.svh"

module vrf (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  vbe_pkg::vreg_idx_t  [`VBE_NUM_RD-1:0]  rd_idx,
    output vbe_pkg::vreg_data_t [`VBE_NUM_RD-1:0]  rd_data,
    input  logic [`VBE_NUM_ALU-1:0]                wr_en,
    input  vbe_pkg::vreg_idx_t  [`VBE_NUM_ALU-1:0] wr_idx,
    input  vbe_pkg::vreg_data_t [`VBE_NUM_ALU-1:0] wr_data
);
    import vbe_pkg::*;

    vreg_data_t regs [`VBE_NUM_VREG];

    // Reset pattern: byte e of register r holds 16*r + e
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `VBE_NUM_VREG; r++) begin
                for (int e = 0; e < `VBE_NUM_ELEM; e++) begin
                    regs[r][e*`VBE_SEW +: `VBE_SEW] <= `VBE_SEW'(`VBE_NUM_ELEM * r + e);
                end
            end
        end else begin
            // Later lane overrides on an equal index
            for (int w = 0; w < `VBE_NUM_ALU; w++) begin
                if (wr_en[w]) begin
                    regs[wr_idx[w]] <= wr_data[w];
                end
            end
        end
    end

    // No bypass, the issue stall covers in-flight results
    always_comb begin
        for (int p = 0; p < `VBE_NUM_RD; p++) begin
            rd_data[p] = regs[rd_idx[p]];
        end
    end

endmodule

//--- design/retire_unit.sv
`timescale 1ns/1ns
`include "vbe_consts.svh"

module retire_unit (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [`VBE_NUM_ALU-1:0]                  result_valid,
    input  vbe_pkg::lane_result_t [`VBE_NUM_ALU-1:0] result,
    output logic [`VBE_NUM_ALU-1:0]                  wr_en,
    output vbe_pkg::vreg_idx_t [`VBE_NUM_ALU-1:0]    wr_idx,
    output vbe_pkg::vreg_data_t [`VBE_NUM_ALU-1:0]   wr_data,
    output logic [`VBE_NUM_ALU-1:0]                  rt_valid,
    output vbe_pkg::vreg_idx_t [`VBE_NUM_ALU-1:0]    rt_dest,
    output vbe_pkg::vreg_data_t [`VBE_NUM_ALU-1:0]   rt_data,
    output logic                                     vxsat_valid,
    output logic                                     vxsat
);
    logic [`VBE_NUM_ALU-1:0] sat_hit;

    // Register writes go straight from the lane registers
    always_comb begin
        for (int l = 0; l < `VBE_NUM_ALU; l++) begin
            wr_en[l]   = result_valid[l];
            wr_idx[l]  = result[l].vd;
            wr_data[l] = result[l].data;
            sat_hit[l] = result_valid[l] & result[l].sat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rt_valid    <= '0;
            vxsat_valid <= 1'b0;
            vxsat       <= 1'b0;
        end else begin
            rt_valid    <= result_valid;
            vxsat_valid <= |result_valid;
            vxsat       <= |sat_hit;
        end
    end

    // Report payload, same edge as the register write
    always_ff @(posedge clk) begin
        for (int l = 0; l < `VBE_NUM_ALU; l++) begin
            if (result_valid[l]) begin
                rt_dest[l] <= result[l].vd;
                rt_data[l] <= result[l].data;
            end
        end
    end

endmodule

//--- design/vec_backend.sv
`timescale 1ns/1ns
`include "vbe_consts.svh"

module vec_backend (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`VBE_ISSUE_LANE-1:0]              insts_valid,
    input  vbe_pkg::vec_cmd_t [`VBE_ISSUE_LANE-1:0] insts,
    output logic [`VBE_ISSUE_LANE-1:0]              insts_ready,
    output logic [`VBE_NUM_ALU-1:0]                 rt_valid,
    output vbe_pkg::vreg_idx_t [`VBE_NUM_ALU-1:0]   rt_dest,
    output vbe_pkg::vreg_data_t [`VBE_NUM_ALU-1:0]  rt_data,
    output logic                                    vxsat_valid,
    output logic                                    vxsat
);
    import vbe_pkg::*;

    // Queue to issue
    vec_cmd_t                          head0;
    vec_cmd_t                          head1;
    logic [`VBE_CQ_CNT_W-1:0]          cq_count;
    logic [1:0]                        pop_count;
    // Issue to lanes and register file
    logic [`VBE_NUM_ALU-1:0]           issue_valid;
    vec_op_e [`VBE_NUM_ALU-1:0]        issue_op;
    vreg_idx_t [`VBE_NUM_ALU-1:0]      issue_vd;
    vreg_idx_t [`VBE_NUM_RD-1:0]       rd_idx;
    vreg_data_t [`VBE_NUM_RD-1:0]      rd_data;
    // Lanes to retire, retire to register file
    logic [`VBE_NUM_ALU-1:0]           lane_valid;
    lane_result_t [`VBE_NUM_ALU-1:0]   lane_res;
    logic [`VBE_NUM_ALU-1:0]           wr_en;
    vreg_idx_t [`VBE_NUM_ALU-1:0]      wr_idx;
    vreg_data_t [`VBE_NUM_ALU-1:0]     wr_data;

    cmd_queue #(
        .DEPTH      (`VBE_CQ_DEPTH)
    ) u_cmd_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (insts_valid),
        .push_cmd   (insts),
        .ready      (insts_ready),
        .head0      (head0),
        .head1      (head1),
        .count      (cq_count),
        .pop_count  (pop_count)
    );

    issue_ctrl u_issue_ctrl (
        .head0       (head0),
        .head1       (head1),
        .count       (cq_count),
        .lane_busy   (lane_valid),
        .lane_vd     ({lane_res[1].vd, lane_res[0].vd}),
        .pop_count   (pop_count),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_vd    (issue_vd),
        .rd_idx      (rd_idx)
    );

    for (genvar i = 0; i < `VBE_NUM_ALU; i++) begin : gen_lane
        vec_alu_lane u_alu_lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .issue_valid  (issue_valid[i]),
            .op           (issue_op[i]),
            .vd           (issue_vd[i]),
            .opa          (rd_data[2*i]),
            .opb          (rd_data[2*i+1]),
            .result_valid (lane_valid[i]),
            .result       (lane_res[i])
        );
    end

    vrf u_vrf (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

    retire_unit u_retire_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .result_valid (lane_valid),
        .result       (lane_res),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_data      (wr_data),
        .rt_valid     (rt_valid),
        .rt_dest      (rt_dest),
        .rt_data      (rt_data),
        .vxsat_valid  (vxsat_valid),
        .vxsat        (vxsat)
    );

endmodule

//--- verif/vec_backend_properties.sv
`timescale 1ns/1ns
`include "vbe_consts.svh"

module vec_backend_properties (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`VBE_ISSUE_LANE-1:0] insts_valid,
    input  logic [`VBE_ISSUE_LANE-1:0] insts_ready,
    input  logic [`VBE_NUM_ALU-1:0]    rt_valid,
    input  logic                       vxsat_valid
);
    logic [`VBE_ISSUE_LANE-1:0] push_acc;

    assign push_acc = insts_valid & insts_ready;

    // Lane 0 always retires the older instruction
    assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid inside {2'b00, 2'b01, 2'b11})
        else $error("rt_valid shows lane 1 retiring without lane 0");

    // Thermometer: ones only from bit 0 upward
    assert property (@(posedge clk) disable iff (!rst_n)
        (insts_ready & (insts_ready + `VBE_ISSUE_LANE'(1))) == '0)
        else $error("insts_ready is not a thermometer code");

    assert property (@(posedge clk) disable iff (!rst_n)
        (push_acc & (push_acc + `VBE_ISSUE_LANE'(1))) == '0)
        else $error("accepted lanes are not contiguous from lane 0");

    assert property (@(posedge clk) disable iff (!rst_n)
        vxsat_valid |-> (rt_valid != '0))
        else $error("vxsat_valid raised with no retirement");

endmodule

//--- verif/tb_vec_backend.sv
`timescale 1ns/1ns
`include "vbe_consts.svh"

module tb_vec_backend;
    import vbe_pkg::*;

    localparam int SEED        = 32'h40ea_eefc;
    localparam int N_RESET     = 3;
    localparam int N_CHAIN     = 12;
    localparam int N_MIX       = 60;
    localparam int N_SAT       = 24;
    localparam int N_BURST     = 48;
    localparam int N_WAW       = 12;
    localparam int TOTAL_CMDS  = N_RESET + N_CHAIN + N_MIX + N_SAT + N_BURST + N_WAW;
    localparam int CYCLE_LIMIT = 4 * TOTAL_CMDS + 100;

    logic                           clk;
    logic                           rst_n;
    logic [`VBE_ISSUE_LANE-1:0]     insts_valid;
    vec_cmd_t [`VBE_ISSUE_LANE-1:0] insts;
    logic [`VBE_ISSUE_LANE-1:0]     insts_ready;
    logic [`VBE_NUM_ALU-1:0]        rt_valid;
    vreg_idx_t [`VBE_NUM_ALU-1:0]   rt_dest;
    vreg_data_t [`VBE_NUM_ALU-1:0]  rt_data;
    logic                           vxsat_valid;
    logic                           vxsat;

    // Model register file, expected retirements, commands not yet accepted
    vreg_data_t   model_rf [`VBE_NUM_VREG];
    lane_result_t exp_q [$];
    vec_cmd_t     pend_q [$];
    string        test_name;
    int           cycles;
    int           n_sent;
    int           n_retired;

    vec_backend i_dut (.*);

    bind vec_backend vec_backend_properties u_props (.clk, .rst_n, .insts_valid,
                                                      .insts_ready, .rt_valid, .vxsat_valid);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("Some tests failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_dest(input vreg_idx_t exp, input vreg_idx_t act);
        if (act !== exp) begin
            $display("** Error [%s] rt_dest: expected %0d, actual %0d", test_name, exp, act);
            abort_run("retired destination differs from the reference");
        end
    endtask

    task automatic check_data(input vreg_data_t exp, input vreg_data_t act);
        if (act !== exp) begin
            $display("** Error [%s] rt_data: expected %h, actual %h", test_name, exp, act);
            abort_run("retired data differs from the reference");
        end
    endtask

    task automatic check_vxsat(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run("saturation report differs from the reference");
        end
    endtask

    task automatic check_ready(input logic [`VBE_ISSUE_LANE-1:0] exp,
                               input logic [`VBE_ISSUE_LANE-1:0] act);
        if (act !== exp) begin
            $display("** Error [%s] insts_ready: expected %b, actual %b", test_name, exp, act);
            abort_run("insts_ready differs from the expected value");
        end
    endtask

    function automatic vec_cmd_t make_cmd(input vec_op_e op, input int vd,
                                          input int vs1, input int vs2);
        vec_cmd_t c;
        c.op  = op;
        c.vd  = vreg_idx_t'(vd);
        c.vs1 = vreg_idx_t'(vs1);
        c.vs2 = vreg_idx_t'(vs2);
        return c;
    endfunction

    function automatic vec_op_e rand_op();
        return vec_op_e'(2'($urandom_range(3, 0)));
    endfunction

    function automatic int pick_reg(input int lo, input int hi);
        return int'($urandom_range(hi, lo));
    endfunction

    // Registers 0 and 16 keep small reset bytes and 14 and 15 keep large ones
    function automatic int extreme_reg();
        int r;
        r = int'($urandom_range(3, 0));
        return (r == 0) ? 0 : (r == 1) ? 16 : r + 12;
    endfunction

    // Executes one command on the model
    // Subtract forms take vs2 - vs1
    function automatic lane_result_t ref_exec(input vec_cmd_t cmd);
        lane_result_t res;
        int a;
        int b;
        int r;
        res.vd  = cmd.vd;
        res.sat = 1'b0;
        for (int e = 0; e < 16; e++) begin
            a = int'(model_rf[cmd.vs2][8*e +: 8]);
            b = int'(model_rf[cmd.vs1][8*e +: 8]);
            case (cmd.op)
                OP_ADD:   r = (a + b) % 256;
                OP_SUB:   r = (a - b + 256) % 256;
                OP_SADDU: begin
                    r       = (a + b > 255) ? 255 : a + b;
                    res.sat = res.sat | (a + b > 255);
                end
                default: begin
                    r       = (a < b) ? 0 : a - b;
                    res.sat = res.sat | (a < b);
                end
            endcase
            res.data[8*e +: 8] = 8'(r);
        end
        model_rf[cmd.vd] = res.data;
        return res;
    endfunction

    // Offers pending commands oldest on lane 0 and waits for all retirements
    task automatic run_pending(input int lo, input int hi);
        int n_offer;
        int n_acc;
        n_offer = 0;
        while (pend_q.size() > 0) begin
            @(posedge clk);
            // Refused commands stay on offer and new ones join behind them
            n_offer = n_offer + int'($urandom_range(hi, lo));
            if (n_offer > `VBE_ISSUE_LANE) begin
                n_offer = `VBE_ISSUE_LANE;
            end
            if (n_offer > pend_q.size()) begin
                n_offer = pend_q.size();
            end
            for (int k = 0; k < `VBE_ISSUE_LANE; k++) begin
                insts_valid[k] <= (k < n_offer);
                insts[k]       <= (k < n_offer) ? pend_q[k] : '0;
            end
            @(negedge clk);
            n_acc = 0;
            for (int k = 0; k < n_offer; k++) begin
                if (insts_ready[k]) begin
                    exp_q.push_back(ref_exec(pend_q[0]));
                    void'(pend_q.pop_front());
                    n_acc++;
                end
            end
            n_sent  = n_sent + n_acc;
            n_offer = n_offer - n_acc;
        end
        @(posedge clk);
        insts_valid <= '0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
        end
        // Idle cycles catch stray retirements
        repeat (3) @(negedge clk);
    endtask

    // Compare retirements in lane order against the expected queue
    always @(negedge clk) begin : compare_retire
        lane_result_t exp_entry;
        logic         exp_sat;
        if (rst_n) begin
            exp_sat = 1'b0;
            for (int l = 0; l < `VBE_NUM_ALU; l++) begin
                if (rt_valid[l] && exp_q.size() == 0) begin
                    abort_run("retirement seen with no command outstanding");
                end else if (rt_valid[l]) begin
                    exp_entry = exp_q.pop_front();
                    check_dest(exp_entry.vd, rt_dest[l]);
                    check_data(exp_entry.data, rt_data[l]);
                    exp_sat = exp_sat | exp_entry.sat;
                    n_retired++;
                end
            end
            check_vxsat("vxsat_valid", |rt_valid, vxsat_valid);
            if (vxsat_valid) begin
                check_vxsat("vxsat", exp_sat, vxsat);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        abort_run("timeout, retirements stopped arriving");
    end

    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        insts_valid = '0;
        insts       = '0;
        n_sent      = 0;
        n_retired   = 0;
        test_name   = "reset";
        // Byte k of register r starts as 16*r + k
        for (int r = 0; r < `VBE_NUM_VREG; r++) begin
            for (int e = 0; e < 16; e++) begin
                model_rf[r][8*e +: 8] = 8'(16 * r + e);
            end
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_ready({`VBE_ISSUE_LANE{1'b1}}, insts_ready);
        repeat (6) @(negedge clk);
        // Clear r31 and copy untouched registers through it
        pend_q.push_back(make_cmd(OP_SSUBU, 31, 31, 31));
        pend_q.push_back(make_cmd(OP_ADD, 30, 31, 5));
        pend_q.push_back(make_cmd(OP_ADD, 29, 31, 17));
        run_pending(1, 4);

        test_name = "dependent chain";
        for (int i = 0; i < N_CHAIN; i++) begin
            pend_q.push_back(make_cmd(rand_op(), i + 1, i, pick_reg(0, 31)));
        end
        run_pending(1, 4);

        // Runs while the extreme registers still hold their reset bytes
        test_name = "saturation";
        for (int i = 0; i < N_SAT; i++) begin
            pend_q.push_back(make_cmd(($urandom_range(1, 0) != 0) ? OP_SADDU : OP_SSUBU,
                                      pick_reg(22, 27), extreme_reg(), extreme_reg()));
        end
        run_pending(2, 4);

        test_name = "random mix";
        for (int i = 0; i < N_MIX; i++) begin
            pend_q.push_back(make_cmd(rand_op(), pick_reg(0, 31), pick_reg(0, 31),
                                      pick_reg(0, 31)));
        end
        run_pending(0, 4);

        // Tight dependences keep the queue full
        test_name = "full bursts";
        for (int i = 0; i < N_BURST; i++) begin
            pend_q.push_back(make_cmd(rand_op(), pick_reg(8, 11), pick_reg(8, 11),
                                      pick_reg(8, 11)));
        end
        run_pending(4, 4);

        // Each group starts on idle lanes so both writes to r12 issue together
        test_name = "same destination pairs";
        for (int g = 0; g < N_WAW / 3; g++) begin
            pend_q.push_back(make_cmd(rand_op(), 12, pick_reg(0, 7), pick_reg(0, 7)));
            pend_q.push_back(make_cmd(rand_op(), 12, pick_reg(0, 7), pick_reg(0, 7)));
            pend_q.push_back(make_cmd(OP_ADD, 13 + g, 12, 12));
            run_pending(4, 4);
        end

        test_name = "final";
        if (n_retired == n_sent && n_sent == TOTAL_CMDS && exp_q.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run("number of retirements does not match the commands sent");
        end
    end

endmodule

//--- filelist.f
+incdir+common
common/vbe_pkg.sv
cmd_queue/cmd_queue.sv
design/issue_ctrl.sv
design/vec_alu_lane.sv
design/vrf.sv
design/retire_unit.sv
design/vec_backend.sv
verif/vec_backend_properties.sv
verif/tb_vec_backend.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   := filelist.f
TOP        := tb_vec_backend
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
